//--- logic/clkmgr_pkg.sv
/*
  Hint clock manager shared definitions.
  Holds the unit count, the idle threshold, the multi-bit encoding and
  the structs passed between control, hint units and status.
*/

package clkmgr_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // number of hintable units
  localparam int NumHints = 4;

  // idle counter width and the count a unit must reach before gating
  localparam int IdleCntW = 4;
  localparam logic [IdleCntW-1:0] IdleCnt = 4'd10;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // only these two 4-bit patterns are legal
  // true on the gated indication means the clock is off
  typedef enum logic [3:0] {
    MuBi4True  = 4'h6,
    MuBi4False = 4'h9
  } mubi4_e;

  // position of each unit in the hint register and idle vector
  typedef enum logic [$clog2(NumHints)-1:0] {
    HintMainAes  = 2'd0,
    HintMainHmac = 2'd1,
    HintMainKmac = 2'd2,
    HintMainOtbn = 2'd3
  } hint_idx_e;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // broadcast from the control block to every unit
  typedef struct packed {
    logic                root_en;
    logic [NumHints-1:0] hints;
  } hint_ctrl_t;

  // per unit result collected by the status block
  typedef struct packed {
    logic   en;
    mubi4_e cg_en;
    logic   cnt_err;
  } trans_out_t;

endpackage

//--- logic/clkmgr_hint_ctrl.sv
/*
  Hint control.
  Software hint register and the two-flop synchroniser for the power
  manager main clock enable, presented together to all hint units.
*/

`timescale 1ns/1ps

module clkmgr_hint_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            hint_we_i,
  input  logic [clkmgr_pkg::NumHints-1:0] hint_wdata_i,
  input  logic                            pwr_main_en_i,
  output clkmgr_pkg::hint_ctrl_t          ctrl_o
);

  import clkmgr_pkg::*;

  logic [NumHints-1:0] hint_q;
  logic [1:0]          root_en_sync_q;

  //////////////////////////////////////////////////////////////////////
  // software hints
  //////////////////////////////////////////////////////////////////////

  // every unit comes out of reset hinted on
  // a write replaces all hint bits at once
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hint_q <= '1;
    end else if (hint_we_i) begin
      hint_q <= hint_wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // root enable
  //////////////////////////////////////////////////////////////////////

  // the power manager enable arrives from another domain
  // bit 0 is the first stage and bit 1 feeds the units
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      root_en_sync_q <= '0;
    end else begin
      root_en_sync_q <= {root_en_sync_q[0], pwr_main_en_i};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign ctrl_o.root_en = root_en_sync_q[1];
  assign ctrl_o.hints   = hint_q;

  // hints only move as the result of a software write
  hint_write_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$stable(hint_q) |-> $past(hint_we_i)
  );

endmodule

//--- logic/clkmgr_trans.sv
/*
  Hintable clock unit.
  Counts idle cycles in two copies and gates its clock once software has
  dropped the hint and the unit stayed idle long enough.
*/

`timescale 1ns/1ps

module clkmgr_trans #(
  parameter clkmgr_pkg::hint_idx_e HintIdx = clkmgr_pkg::HintMainAes
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  clkmgr_pkg::hint_ctrl_t ctrl_i,
  input  logic                   idle_i,
  output logic                   clk_o,
  output clkmgr_pkg::trans_out_t out_o
);

  import clkmgr_pkg::*;

  // progress of the idle count, decoded from the primary copy
  typedef enum logic [1:0] {
    IdleBusy,
    IdleCounting,
    IdleDone
  } idle_state_e;

  logic                sw_hint;
  logic [IdleCntW-1:0] cnt_a_q;
  logic [IdleCntW-1:0] cnt_b_q;
  idle_state_e         idle_state;
  logic                en_d;
  logic                en_q;
  logic                en_latch;
  mubi4_e              cg_en_q;

  // clear on busy or root off, count up and stick at the threshold
  function automatic logic [IdleCntW-1:0] idle_cnt_next(
    input logic [IdleCntW-1:0] cnt,
    input logic                idle,
    input logic                root_en
  );
    logic [IdleCntW-1:0] nxt;
    if (!idle || !root_en) begin
      nxt = '0;
    end else if (cnt < IdleCnt) begin
      nxt = cnt + 1'b1;
    end else begin
      nxt = cnt;
    end
    return nxt;
  endfunction

  assign sw_hint = ctrl_i.hints[HintIdx];

  //////////////////////////////////////////////////////////////////////
  // idle counting
  //////////////////////////////////////////////////////////////////////

  // each copy advances from its own value so a fault shows as a mismatch
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_a_q <= '0;
      cnt_b_q <= '0;
    end else begin
      cnt_a_q <= idle_cnt_next(cnt_a_q, idle_i, ctrl_i.root_en);
      cnt_b_q <= idle_cnt_next(cnt_b_q, idle_i, ctrl_i.root_en);
    end
  end

  always_comb begin
    if (cnt_a_q == '0) begin
      idle_state = IdleBusy;
    end else if (cnt_a_q < IdleCnt) begin
      idle_state = IdleCounting;
    end else begin
      idle_state = IdleDone;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // enable and clock gate
  //////////////////////////////////////////////////////////////////////

  // stay on while hinted or not yet idle long enough
  assign en_d = ctrl_i.root_en & (sw_hint | (idle_state != IdleDone));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q    <= 1'b0;
      cg_en_q <= MuBi4True;
    end else begin
      en_q    <= en_d;
      cg_en_q <= en_q ? MuBi4False : MuBi4True;
    end
  end

  // enable is captured while the clock is low so clk_o has no glitches
  always_latch begin
    if (!clk_i) begin
      en_latch = en_q;
    end
  end

  assign clk_o = clk_i & en_latch;

  assign out_o.en      = en_q;
  assign out_o.cg_en   = cg_en_q;
  assign out_o.cnt_err = (cnt_a_q != cnt_b_q);

  // neither copy may run past the threshold
  cnt_bound_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (cnt_a_q <= IdleCnt) && (cnt_b_q <= IdleCnt)
  );

  // indication is always a legal code
  cg_en_code_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cg_en_q inside {MuBi4True, MuBi4False}
  );

endmodule

//--- logic/clkmgr_hint_status.sv
/*
  Hint status.
  Registers unit enables and gated indications for readback, reports the
  root enable back to the power manager and holds the fatal count error.
*/

`timescale 1ns/1ps

module clkmgr_hint_status (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic                                               root_en_i,
  input  clkmgr_pkg::trans_out_t [clkmgr_pkg::NumHints-1:0] units_i,
  output logic [clkmgr_pkg::NumHints-1:0]                    hints_status_o,
  output clkmgr_pkg::mubi4_e [clkmgr_pkg::NumHints-1:0]     cg_en_o,
  output logic                                               main_status_o,
  output logic                                               fatal_err_o
);

  import clkmgr_pkg::*;

  logic [NumHints-1:0] unit_en;
  logic [NumHints-1:0] unit_cnt_err;

  // split the unit structs into flat vectors
  always_comb begin
    for (int i = 0; i < NumHints; i++) begin
      unit_en[i]      = units_i[i].en;
      unit_cnt_err[i] = units_i[i].cnt_err;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback and power status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hints_status_o <= '0;
      main_status_o  <= 1'b0;
      for (int i = 0; i < NumHints; i++) begin
        cg_en_o[i] <= MuBi4True;
      end
    end else begin
      hints_status_o <= unit_en;
      main_status_o  <= root_en_i;
      for (int i = 0; i < NumHints; i++) begin
        cg_en_o[i] <= units_i[i].cg_en;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fatal error
  //////////////////////////////////////////////////////////////////////

  // any counter mismatch is permanent until the next reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fatal_err_o <= 1'b0;
    end else if (|unit_cnt_err) begin
      fatal_err_o <= 1'b1;
    end
  end

  fatal_sticky_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    fatal_err_o |=> fatal_err_o
  );

endmodule

//--- logic/clkmgr_hints.sv
/*
  Hint clock manager top level.
  Control block feeding one clock unit per hintable block, with the
  status block collecting their results.
*/

`timescale 1ns/1ps

module clkmgr_hints (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  logic                                           hint_we_i,
  input  logic [clkmgr_pkg::NumHints-1:0]                hint_wdata_i,
  input  logic                                           pwr_main_en_i,
  input  logic [clkmgr_pkg::NumHints-1:0]                idle_i,
  output logic [clkmgr_pkg::NumHints-1:0]                clocks_o,
  output logic [clkmgr_pkg::NumHints-1:0]                hints_status_o,
  output clkmgr_pkg::mubi4_e [clkmgr_pkg::NumHints-1:0] cg_en_o,
  output logic                                           main_status_o,
  output logic                                           fatal_err_o
);

  import clkmgr_pkg::*;

  hint_ctrl_t                ctrl;
  trans_out_t [NumHints-1:0] units;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  clkmgr_hint_ctrl u_hint_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .hint_we_i     (hint_we_i),
    .hint_wdata_i  (hint_wdata_i),
    .pwr_main_en_i (pwr_main_en_i),
    .ctrl_o        (ctrl)
  );

  //////////////////////////////////////////////////////////////////////
  // hint units
  //////////////////////////////////////////////////////////////////////

  // unit i serves hint bit i and idle bit i
  for (genvar i = 0; i < NumHints; i++) begin : gen_trans
    clkmgr_trans #(
      .HintIdx (hint_idx_e'(i))
    ) u_trans (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .ctrl_i (ctrl),
      .idle_i (idle_i[i]),
      .clk_o  (clocks_o[i]),
      .out_o  (units[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////

  clkmgr_hint_status u_hint_status (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .root_en_i      (ctrl.root_en),
    .units_i        (units),
    .hints_status_o (hints_status_o),
    .cg_en_o        (cg_en_o),
    .main_status_o  (main_status_o),
    .fatal_err_o    (fatal_err_o)
  );

endmodule

//--- sim/clkmgr_hints_checks.svh
/*
  Hint clock manager compare tasks.
  One task per kind of result, each keeping its own error count.
*/

`ifndef CLKMGR_HINTS_CHECKS_SVH
`define CLKMGR_HINTS_CHECKS_SVH

int status_errs = 0;
int cg_errs     = 0;
int bit_errs    = 0;
int clk_errs    = 0;

// readback of the per-unit enables
task automatic check_status(
  input logic [clkmgr_pkg::NumHints-1:0] got,
  input logic [clkmgr_pkg::NumHints-1:0] exp,
  input string                           what
);
  if (got !== exp) begin
    status_errs++;
    $display("FAIL %0t: %s hints_status_o is %b, expected %b", $time, what, got, exp);
  end
endtask

// gated clocks, sampled while the source clock is high
task automatic check_clocks(
  input logic [clkmgr_pkg::NumHints-1:0] got,
  input logic [clkmgr_pkg::NumHints-1:0] exp,
  input string                           what
);
  if (got !== exp) begin
    clk_errs++;
    $display("FAIL %0t: %s clocks_o is %b, expected %b", $time, what, got, exp);
  end
endtask

// gated indication, reported unit by unit
task automatic check_cg_en(
  input clkmgr_pkg::mubi4_e [clkmgr_pkg::NumHints-1:0] got,
  input clkmgr_pkg::mubi4_e [clkmgr_pkg::NumHints-1:0] exp,
  input string                                         what
);
  clkmgr_pkg::hint_idx_e idx;
  for (int i = 0; i < clkmgr_pkg::NumHints; i++) begin
    idx = clkmgr_pkg::hint_idx_e'(i);
    if (got[i] !== exp[i]) begin
      cg_errs++;
      $display("FAIL %0t: %s cg_en_o of %s is %h, expected %h",
               $time, what, idx.name(), got[i], exp[i]);
    end
  end
endtask

// single status outputs
task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    bit_errs++;
    $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

//--- sim/clkmgr_hints_tb.sv
/*
  Hint clock manager testbench.
  Applies a table of hint writes, idle patterns and root enables, then
  compares status readback against the gating rule after settling.
*/

`timescale 1ns/1ps

module clkmgr_hints_tb;

  import clkmgr_pkg::*;

  `include "clkmgr_hints_checks.svh"

  localparam int ResetCycles    = 16;
  localparam int SettleCycles   = int'(IdleCnt) + 6;
  localparam int NumRows        = 12;
  localparam int MaxIdleRun     = 4;
  localparam int WatchdogCycles = NumRows * (SettleCycles + 2) + ResetCycles + 100;

  // one table row, bit n of each vector belongs to unit n
  typedef struct packed {
    logic                  we;
    logic [NumHints-1:0]   wdata;
    logic                  pwr_en;
    logic [NumHints-1:0]   idle;
    logic [NumHints-1:0]   rand_mask;
    logic [NumHints-1:0]   exp_status;
    mubi4_e [NumHints-1:0] exp_cg;
    logic                  exp_main;
  } row_t;

  logic                  clk_i;
  logic                  rst_i;
  logic                  hint_we_i;
  logic [NumHints-1:0]   hint_wdata_i;
  logic                  pwr_main_en_i;
  logic [NumHints-1:0]   idle_i;
  logic [NumHints-1:0]   clocks_o;
  logic [NumHints-1:0]   hints_status_o;
  mubi4_e [NumHints-1:0] cg_en_o;
  logic                  main_status_o;
  logic                  fatal_err_o;
  row_t                  rows [NumRows];
  int                    idle_run [NumHints];
  int                    total_errs;

  clkmgr_hints DUT (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .hint_we_i      (hint_we_i),
    .hint_wdata_i   (hint_wdata_i),
    .pwr_main_en_i  (pwr_main_en_i),
    .idle_i         (idle_i),
    .clocks_o       (clocks_o),
    .hints_status_o (hints_status_o),
    .cg_en_o        (cg_en_o),
    .main_status_o  (main_status_o),
    .fatal_err_o    (fatal_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("timeout: the stimulus table did not finish within %0d cycles", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  // gated units read MuBi4True, running units MuBi4False
  function automatic mubi4_e [NumHints-1:0] cg_vec(input logic [NumHints-1:0] gated);
    mubi4_e [NumHints-1:0] vec;
    for (int i = 0; i < NumHints; i++) begin
      vec[i] = gated[i] ? MuBi4True : MuBi4False;
    end
    return vec;
  endfunction

  function automatic row_t make_row(
    input logic                we,
    input logic [NumHints-1:0] wdata,
    input logic                pwr_en,
    input logic [NumHints-1:0] idle,
    input logic [NumHints-1:0] rand_mask,
    input logic [NumHints-1:0] exp_status,
    input logic                exp_main
  );
    row_t row;
    row.we         = we;
    row.wdata      = wdata;
    row.pwr_en     = pwr_en;
    row.idle       = idle;
    row.rand_mask  = rand_mask;
    row.exp_status = exp_status;
    row.exp_cg     = cg_vec(~exp_status);
    row.exp_main   = exp_main;
    return row;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  // bit order is otbn, kmac, hmac, aes
  task automatic load_rows();
    // no write, so the reset hints keep every unit on
    rows[0]  = make_row(1'b0, 4'b0000, 1'b1, 4'b1111, 4'b0000, 4'b1111, 1'b1);
    rows[1]  = make_row(1'b1, 4'b1111, 1'b1, 4'b0000, 4'b0000, 4'b1111, 1'b1);
    rows[2]  = make_row(1'b1, 4'b1110, 1'b1, 4'b0001, 4'b0000, 4'b1110, 1'b1);
    rows[3]  = make_row(1'b1, 4'b0000, 1'b1, 4'b0101, 4'b0000, 4'b1010, 1'b1);
    rows[4]  = make_row(1'b1, 4'b0100, 1'b1, 4'b1111, 4'b0000, 4'b0100, 1'b1);
    // noisy idle never lasts long enough to gate
    rows[5]  = make_row(1'b1, 4'b0000, 1'b1, 4'b1100, 4'b0001, 4'b0011, 1'b1);
    rows[6]  = make_row(1'b1, 4'b0000, 1'b1, 4'b0000, 4'b1010, 4'b1111, 1'b1);
    // root enable off and back on
    rows[7]  = make_row(1'b1, 4'b1111, 1'b0, 4'b0000, 4'b0000, 4'b0000, 1'b0);
    rows[8]  = make_row(1'b1, 4'b1111, 1'b1, 4'b0000, 4'b0000, 4'b1111, 1'b1);
    rows[9]  = make_row(1'b1, 4'b0011, 1'b0, 4'b1111, 4'b0000, 4'b0000, 1'b0);
    rows[10] = make_row(1'b1, 4'b0011, 1'b1, 4'b1111, 4'b0000, 4'b0011, 1'b1);
    rows[11] = make_row(1'b1, 4'b1111, 1'b1, 4'b1111, 4'b0000, 4'b1111, 1'b1);
  endtask

  // random bits are forced low after MaxIdleRun high cycles
  task automatic drive_idle(input row_t row);
    logic [NumHints-1:0] vec;
    logic [31:0]         rnd;
    vec = row.idle;
    for (int i = 0; i < NumHints; i++) begin
      if (row.rand_mask[i]) begin
        rnd = $urandom;
        if (rnd[0] && (idle_run[i] < MaxIdleRun)) begin
          vec[i] = 1'b1;
          idle_run[i]++;
        end else begin
          vec[i] = 1'b0;
          idle_run[i] = 0;
        end
      end
    end
    idle_i <= vec;
  endtask

  task automatic apply_row(input int idx);
    row_t  row;
    string tag;
    row = rows[idx];
    tag = $sformatf("row %0d", idx);
    for (int i = 0; i < NumHints; i++) begin
      idle_run[i] = 0;
    end
    @(posedge clk_i);
    hint_we_i     <= row.we;
    hint_wdata_i  <= row.wdata;
    pwr_main_en_i <= row.pwr_en;
    drive_idle(row);
    repeat (SettleCycles) begin
      @(posedge clk_i);
      hint_we_i <= 1'b0;
      drive_idle(row);
    end
    @(negedge clk_i);
    check_status(hints_status_o, row.exp_status, tag);
    check_cg_en(cg_en_o, row.exp_cg, tag);
    check_bit(main_status_o, row.exp_main, {tag, " main_status_o"});
    check_bit(fatal_err_o, 1'b0, {tag, " fatal_err_o"});
    // middle of the high phase, where an enabled unit's clock is high
    @(posedge clk_i);
    #5;
    check_clocks(clocks_o, row.exp_status, tag);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(21431));
    rst_i         <= 1'b1;
    hint_we_i     <= 1'b0;
    hint_wdata_i  <= '0;
    pwr_main_en_i <= 1'b0;
    idle_i        <= '0;
    load_rows();
    repeat (ResetCycles) @(posedge clk_i);
    rst_i <= 1'b0;

    // reset values before any stimulus
    @(negedge clk_i);
    check_status(hints_status_o, '0, "reset");
    check_cg_en(cg_en_o, cg_vec('1), "reset");
    check_bit(main_status_o, 1'b0, "reset main_status_o");
    check_bit(fatal_err_o, 1'b0, "reset fatal_err_o");

    for (int r = 0; r < NumRows; r++) begin
      apply_row(r);
    end
    check_bit(fatal_err_o, 1'b0, "end of run fatal_err_o");

    total_errs = status_errs + cg_errs + bit_errs + clk_errs;
    $display("errors: status %0d, cg_en %0d, single bits %0d, clocks %0d, total %0d",
             status_errs, cg_errs, bit_errs, clk_errs, total_errs);
    if (total_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+sim
logic/clkmgr_pkg.sv
logic/clkmgr_hint_ctrl.sv
logic/clkmgr_trans.sv
logic/clkmgr_hint_status.sv
logic/clkmgr_hints.sv
sim/clkmgr_hints_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hint clock manager testbench with Verilator
# the run counts as passed only when the log holds the pass message

LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert -f flist.f \
  --top-module clkmgr_hints_tb -o clkmgr_hints_sim \
  && ./obj_dir/clkmgr_hints_sim > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"

grep -q "Test completed successfully" "$LOG" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
